/* common/text_pkg.sv */
package text_pkg;

  typedef logic [7:0] char_code_t;

  localparam char_code_t CHAR_DIGIT0 = 8'h30;
  localparam char_code_t CHAR_COLON  = 8'h3a;
  localparam char_code_t CHAR_A      = 8'h3b;
  localparam char_code_t CHAR_B      = 8'h3c;
  localparam char_code_t CHAR_SPACE  = 8'h20;

  // font ROM holds 30h..3Ch only
  localparam char_code_t GLYPH_FIRST = 8'h30;
  localparam int         GLYPH_COUNT = 13;

  typedef logic [0:15][7:0] glyph_t;      // row 0 in the top byte
  typedef char_code_t [0:9] text_row_t;   // column 0 leftmost

  typedef struct packed {
    logic [3:0] op_tens;
    logic [3:0] op_ones;
    logic [3:0] a_tens;
    logic [3:0] a_ones;
    logic [3:0] b_tens;
    logic [3:0] b_ones;
  } operand_set_t;

  typedef struct packed {
    logic [3:0] tens;
    logic [3:0] ones;
  } bcd2_t;

endpackage

/* common/video_pkg.sv */
package video_pkg;

  typedef logic [9:0] coord_t;  // screen coordinate, pixels or lines

  // horizontal timing in pixels
  localparam int unsigned H_ACTIVE     = 640;
  localparam int unsigned H_SYNC_START = 656;
  localparam int unsigned H_SYNC_END   = 752;
  localparam int unsigned H_LINE       = 800;

  // vertical timing in lines
  localparam int unsigned V_ACTIVE     = 480;
  localparam int unsigned V_SYNC_START = 490;
  localparam int unsigned V_SYNC_END   = 492;
  localparam int unsigned V_FRAME      = 525;

  typedef struct packed {
    coord_t sx;
    coord_t sy;
    logic   hsync;  // negative polarity
    logic   vsync;  // negative polarity
    logic   de;
  } raster_t;

  // pipeline register contents while in reset
  localparam raster_t RASTER_IDLE = '{sx: '0, sy: '0, hsync: 1'b1, vsync: 1'b1, de: 1'b0};

  typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
  } rgb332_t;

  localparam rgb332_t COLOUR_FG    = '{red: 3'd7, green: 3'd6, blue: 2'd0};  // yellow text
  localparam rgb332_t COLOUR_BG    = '{red: 3'd0, green: 3'd1, blue: 2'd1};  // dark blue
  localparam rgb332_t COLOUR_BLANK = '{red: 3'd0, green: 3'd0, blue: 2'd0};

endpackage

/* raster/raster_timing.sv */
module raster_timing
  import video_pkg::*;
(
  input  logic    clk_50M,
  input  logic    reset_btn,
  output logic    pix_en,
  output raster_t raster
);

  coord_t sx, sy;

  // pix_en toggles, first high on the second clock out of reset
  always_ff @(posedge clk_50M) begin
    if (reset_btn) begin
      pix_en <= 1'b0;
      sx     <= '0;
      sy     <= '0;
    end else begin
      pix_en <= ~pix_en;
      if (pix_en) begin
        if (sx == H_LINE - 1) begin  // end of line
          sx <= '0;
          sy <= (sy == V_FRAME - 1) ? '0 : sy + 1'b1;
        end else begin
          sx <= sx + 1'b1;
        end
      end
    end
  end

  always_comb begin
    raster.sx    = sx;
    raster.sy    = sy;
    raster.hsync = ~(sx >= H_SYNC_START && sx < H_SYNC_END);  // active low
    raster.vsync = ~(sy >= V_SYNC_START && sy < V_SYNC_END);
    raster.de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
  end

  // counters stay inside the 800x525 frame
  sx_in_line: assert property (@(posedge clk_50M) disable iff (reset_btn)
    sx < H_LINE && sy < V_FRAME)
    else $error("raster position out of frame");

endmodule

/* rtl/pixel_paint.sv */
module pixel_paint
  import video_pkg::*;
(
  input  logic    clk_50M,
  input  logic    reset_btn,
  input  logic    pix_en,
  input  raster_t raster_in,
  input  logic    lit,
  output rgb332_t pixel,
  output logic    hsync,
  output logic    vsync,
  output logic    de
);

  always_ff @(posedge clk_50M) begin
    if (reset_btn) begin
      pixel <= COLOUR_BLANK;
      hsync <= 1'b1;  // sync idles high
      vsync <= 1'b1;
      de    <= 1'b0;
    end else if (pix_en) begin
      if (!raster_in.de) pixel <= COLOUR_BLANK;  // black in blanking
      else               pixel <= lit ? COLOUR_FG : COLOUR_BG;
      hsync <= raster_in.hsync;
      vsync <= raster_in.vsync;
      de    <= raster_in.de;
    end
  end

  blank_when_no_de: assert property (@(posedge clk_50M) !de |-> pixel == COLOUR_BLANK)
    else $error("colour driven outside active video");

endmodule

/* rtl/tick_counter.sv */
module tick_counter
  import text_pkg::*;
#(
  parameter int TICK_CYCLES = 50_000_000
) (
  input  logic  clk_50M,
  input  logic  reset_btn,
  output bcd2_t elapsed_bcd
);

  localparam int PW = $clog2(TICK_CYCLES + 1);

  logic [PW-1:0] prescale;
  logic [4:0]    count;  // wraps 31 -> 0

  always_ff @(posedge clk_50M) begin
    if (reset_btn) begin
      prescale <= '0;
      count    <= '0;
    end else if (prescale == PW'(TICK_CYCLES - 1)) begin
      prescale <= '0;
      count    <= count + 1'b1;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // double dabble over the 5 count bits
  function automatic bcd2_t to_bcd(input logic [4:0] bin);
    logic [3:0] hi, lo;
    hi = '0;
    lo = '0;
    for (int i = 4; i >= 0; i--) begin
      if (lo >= 4'd5) lo = lo + 4'd3;
      if (hi >= 4'd5) hi = hi + 4'd3;
      hi = {hi[2:0], lo[3]};
      lo = {lo[2:0], bin[i]};
    end
    return '{tens: hi, ones: lo};
  endfunction

  assign elapsed_bcd = to_bcd(count);

endmodule

/* rtl/vga_text_top.sv */
module vga_text_top
  import video_pkg::*;
  import text_pkg::*;
#(
  parameter int TICK_CYCLES = 50_000_000
) (
  input  logic         clk_50M,
  input  logic         reset_btn,
  input  operand_set_t operands,
  input  logic         load_req,
  output logic         load_ack,
  output logic [2:0]   video_red,
  output logic [2:0]   video_green,
  output logic [1:0]   video_blue,
  output logic         video_hsync,
  output logic         video_vsync,
  output logic         video_de
);

  logic         pix_en;
  raster_t      raster_s0, raster_s1, raster_s2;
  operand_set_t shown;
  bcd2_t        elapsed_bcd;
  char_code_t   char_code;
  logic [3:0]   glyph_row;
  logic [2:0]   glyph_col;
  logic         lit;
  rgb332_t      pixel;

  raster_timing raster_inst (.clk_50M, .reset_btn, .pix_en, .raster(raster_s0));

  operand_latch latch_inst (.clk_50M, .reset_btn, .operands, .load_req, .load_ack, .shown);

  tick_counter #(.TICK_CYCLES(TICK_CYCLES)) tick_inst (.clk_50M, .reset_btn, .elapsed_bcd);

  char_fetch char_inst (
    .clk_50M, .reset_btn, .pix_en,
    .raster_in(raster_s0), .shown, .elapsed_bcd,
    .raster_out(raster_s1), .char_code, .glyph_row, .glyph_col
  );

  glyph_fetch glyph_inst (
    .clk_50M, .reset_btn, .pix_en,
    .raster_in(raster_s1), .char_code, .glyph_row, .glyph_col,
    .raster_out(raster_s2), .lit
  );

  pixel_paint paint_inst (
    .clk_50M, .reset_btn, .pix_en,
    .raster_in(raster_s2), .lit,
    .pixel, .hsync(video_hsync), .vsync(video_vsync), .de(video_de)
  );

  assign video_red   = pixel.red;
  assign video_green = pixel.green;
  assign video_blue  = pixel.blue;

endmodule

/* sim/tb_vga_text.sv */
module tb_vga_text
  import video_pkg::*;
  import text_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TICK_CYCLES  = 3000;
  localparam int LINE_CLOCKS  = 2 * H_LINE;  // two clocks per pixel
  localparam int FRAME_CLOCKS = LINE_CLOCKS * V_FRAME;
  localparam int CAPTURE_LAG  = 5;  // count seen by char_fetch, relative to the paint sample
  localparam int SIG_HSYNC = 0, SIG_VSYNC = 1, SIG_DE = 2, SIG_ACK = 3;

  logic         clk_50M = 1'b0;
  logic         reset_btn = 1'b1;
  operand_set_t operands = '0;
  logic         load_req = 1'b0;
  logic         load_ack;
  logic [2:0]   video_red, video_green;
  logic [1:0]   video_blue;
  logic         video_hsync, video_vsync, video_de;
  rgb332_t      video_pixel;

  logic [127:0] font_model [0:12];  // same font file as the DUT
  logic [31:0]  lfsr_state = 32'hbca6_88b9;
  int           error_count = 0, tests_run = 0, tests_failed = 0;
  bit           timed_out = 0;
  operand_set_t shown_ops = '0;
  int           run_clocks, model_sx, model_sy;
  bit           model_locked, model_phase;

  vga_text_top #(.TICK_CYCLES(TICK_CYCLES)) dut0 (
    .clk_50M, .reset_btn, .operands, .load_req, .load_ack,
    .video_red, .video_green, .video_blue, .video_hsync, .video_vsync, .video_de
  );

  assign video_pixel = '{red: video_red, green: video_green, blue: video_blue};

  initial $readmemh("text/glyph_rom.mem", font_model);

  always #10 clk_50M = ~clk_50M;

  // raster model, locks on the first visible pixel after reset
  always @(posedge clk_50M) begin
    if (reset_btn) begin
      run_clocks   <= 0;
      model_locked <= 1'b0;
      model_phase  <= 1'b0;
      model_sx     <= 0;
      model_sy     <= 0;
    end else begin
      run_clocks <= run_clocks + 1;
      if (!model_locked) begin
        if (video_de && video_hsync && video_vsync) begin
          model_locked <= 1'b1;
          model_phase  <= 1'b1;  // pixel (0,0) already shown since last edge
        end
      end else if (model_phase) begin
        model_phase <= 1'b0;
        if (model_sx == H_LINE - 1) begin
          model_sx <= 0;
          model_sy <= (model_sy == V_FRAME - 1) ? 0 : model_sy + 1;
        end else begin
          model_sx <= model_sx + 1;
        end
      end else begin
        model_phase <= 1'b1;
      end
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic logic [3:0] draw_digit();
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[2:0], lfsr_state[0]};
    end
    return v % 10;
  endfunction

  function automatic logic watched(input int which);
    case (which)
      SIG_HSYNC: return video_hsync;
      SIG_VSYNC: return video_vsync;
      SIG_DE:    return video_de;
      default:   return load_ack;
    endcase
  endfunction

  // glyph index per screen cell, -1 for blank
  function automatic rgb332_t expected_pixel(input int x, input int y, input operand_set_t ops,
                                             input int ticks);
    int         g;
    int         col;
    logic [7:0] bits;
    if (x >= H_ACTIVE || y >= V_ACTIVE) return COLOUR_BLANK;
    col = x / 64;
    g = -1;
    case (y / 128)
      0: g = (col == 8) ? ops.op_tens : (col == 9) ? ops.op_ones : -1;
      1: case (col)
           0: g = 11;
           1, 6: g = 10;
           2: g = ops.a_tens;
           3: g = ops.a_ones;
           5: g = 12;
           7: g = ops.b_tens;
           8: g = ops.b_ones;
           default: g = -1;
         endcase
      2: g = (col == 8) ? ticks / 10 : (col == 9) ? ticks % 10 : -1;
      default: g = -1;
    endcase
    if (g < 0) return COLOUR_BG;
    bits = font_model[g][127 - 8 * ((y / 8) % 16) -: 8];
    return bits[7 - (x / 8) % 8] ? COLOUR_FG : COLOUR_BG;
  endfunction

  task automatic check_pixel(input string what, input int x, input int y, input rgb332_t got,
                             input rgb332_t exp);
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s (x %0d, y %0d): got 0x%h, expected 0x%h", what, x, y, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      error_count++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", what, got, exp);
    end
  endtask

  // counts clocks until the signal reaches the level
  task automatic wait_level(input int which, input logic level, input int limit,
                            output int clocks);
    clocks = 0;
    do begin
      @(negedge clk_50M);
      clocks++;
    end while (watched(which) !== level && clocks < limit);
    if (watched(which) !== level) begin
      timed_out = 1;
      error_count++;
      $display("timed out after %0d clocks waiting for output %0d to reach %0b",
               limit, which, level);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failing checks", name, error_count - errs_before);
    end
  endtask

  task automatic load_operands(input operand_set_t ops, output int rise, output int fall);
    @(posedge clk_50M);
    operands <= ops;
    load_req <= 1'b1;
    @(negedge clk_50M);
    check_bit("load_ack before capture", load_ack, 1'b0);
    wait_level(SIG_ACK, 1'b1, 20, rise);
    @(posedge clk_50M);
    load_req <= 1'b0;
    @(negedge clk_50M);
    check_bit("load_ack as req drops", load_ack, 1'b1);
    wait_level(SIG_ACK, 1'b0, 20, fall);
    shown_ops = ops;
  endtask

  task automatic scan_lines(input int first, input int last);
    int waited;
    int ticks;
    waited = 0;
    do begin
      @(negedge clk_50M);
      waited++;
    end while (!(model_locked && model_sx == 0 && model_sy == first && !model_phase)
               && waited < 2 * FRAME_CLOCKS);
    if (!model_locked || model_sx != 0 || model_sy != first || model_phase) begin
      timed_out = 1;
      error_count++;
      $display("timed out waiting for the raster model to reach line %0d", first);
      return;
    end
    for (int i = 0; i < (last - first + 1) * LINE_CLOCKS; i++) begin
      if (!model_phase) begin
        ticks = ((run_clocks - CAPTURE_LAG) / TICK_CYCLES) % 32;
        check_pixel("video pixel", model_sx, model_sy, video_pixel,
                    expected_pixel(model_sx, model_sy, shown_ops, ticks));
      end
      @(negedge clk_50M);
    end
  endtask

  task automatic test_reset_state();
    int errs;
    errs = error_count;
    @(negedge clk_50M);
    check_bit("video_hsync", video_hsync, 1'b1);
    check_bit("video_vsync", video_vsync, 1'b1);
    check_bit("video_de", video_de, 1'b0);
    check_bit("load_ack", load_ack, 1'b0);
    check_pixel("video pixel in reset", 0, 0, video_pixel, COLOUR_BLANK);
    finish_test("reset state", errs);
  endtask

  task automatic test_line_timing();
    int errs, clocks, low, high;
    errs = error_count;
    wait_level(SIG_HSYNC, 1'b1, 2 * LINE_CLOCKS, clocks);
    wait_level(SIG_HSYNC, 1'b0, 2 * LINE_CLOCKS, clocks);
    wait_level(SIG_HSYNC, 1'b1, 2 * LINE_CLOCKS, low);
    wait_level(SIG_HSYNC, 1'b0, 2 * LINE_CLOCKS, high);
    check_count("hsync low clocks", low, 192);
    check_count("hsync period clocks", low + high, LINE_CLOCKS);
    wait_level(SIG_DE, 1'b0, FRAME_CLOCKS, clocks);
    wait_level(SIG_DE, 1'b1, FRAME_CLOCKS, clocks);
    wait_level(SIG_DE, 1'b0, 2 * LINE_CLOCKS, high);
    check_count("de clocks per line", high, 1280);
    finish_test("line timing", errs);
  endtask

  task automatic test_frame_timing();
    int   errs, clocks, low, high, de_clocks, de_lines;
    logic de_prev;
    errs = error_count;
    wait_level(SIG_VSYNC, 1'b1, 2 * FRAME_CLOCKS, clocks);
    wait_level(SIG_VSYNC, 1'b0, 2 * FRAME_CLOCKS, clocks);
    wait_level(SIG_VSYNC, 1'b1, 4 * LINE_CLOCKS, low);
    wait_level(SIG_VSYNC, 1'b0, 2 * FRAME_CLOCKS, high);
    check_count("vsync low clocks", low, 2 * LINE_CLOCKS);
    check_count("vsync period clocks", low + high, FRAME_CLOCKS);
    de_clocks = 0;
    de_lines  = 0;
    de_prev   = video_de;
    for (int i = 0; i < FRAME_CLOCKS; i++) begin
      @(negedge clk_50M);
      if (video_de) de_clocks++;
      if (video_de && !de_prev) de_lines++;  // one rise per active line
      de_prev = video_de;
    end
    check_count("de lines per frame", de_lines, V_ACTIVE);
    check_count("de clocks per frame", de_clocks, V_ACTIVE * 1280);
    finish_test("frame timing", errs);
  endtask

  task automatic test_handshake();
    int           errs, rise, fall;
    operand_set_t ops;
    errs = error_count;
    ops = '{draw_digit(), draw_digit(), draw_digit(), draw_digit(), draw_digit(), draw_digit()};
    load_operands(ops, rise, fall);
    check_count("load_ack rise delay", rise, 1);
    check_count("load_ack fall delay", fall, 1);
    finish_test("handshake", errs);
  endtask

  task automatic test_operand_rows();
    int           errs, rise, fall;
    operand_set_t ops;
    errs = error_count;
    ops = '{draw_digit(), draw_digit(), draw_digit(), draw_digit(), draw_digit(), draw_digit()};
    load_operands(ops, rise, fall);
    scan_lines(0, 255);  // text rows 0 and 1 with their blanking
    finish_test("operand rows", errs);
  endtask

  task automatic test_elapsed_count();
    int errs, clocks;
    errs = error_count;
    wait_level(SIG_VSYNC, 1'b0, 2 * FRAME_CLOCKS, clocks);  // move on to the next frame
    scan_lines(256, 383);
    finish_test("elapsed count", errs);
  endtask

  initial begin
    repeat (10) @(posedge clk_50M);
    reset_btn <= 1'b0;
    test_reset_state();
    if (!timed_out) test_line_timing();
    if (!timed_out) test_frame_timing();
    if (!timed_out) test_handshake();
    if (!timed_out) test_operand_rows();
    if (!timed_out) test_elapsed_count();
    $display("%0d tests run, %0d failed, %0d failing checks", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* src.f */
common/video_pkg.sv
common/text_pkg.sv
raster/raster_timing.sv
text/operand_latch.sv
text/char_fetch.sv
text/glyph_fetch.sv
rtl/tick_counter.sv
rtl/pixel_paint.sv
rtl/vga_text_top.sv
sim/tb_vga_text.sv

/* text/char_fetch.sv */
module char_fetch
  import video_pkg::*;
  import text_pkg::*;
(
  input  logic         clk_50M,
  input  logic         reset_btn,
  input  logic         pix_en,
  input  raster_t      raster_in,
  input  operand_set_t shown,
  input  bcd2_t        elapsed_bcd,
  output raster_t      raster_out,
  output char_code_t   char_code,
  output logic [3:0]   glyph_row,
  output logic [2:0]   glyph_col
);

  text_row_t  row0, row1, row2;
  logic [2:0] text_line;  // sy / 128
  logic [3:0] text_col;   // sx / 64
  char_code_t code_next;

  function automatic char_code_t digit_char(input logic [3:0] nib);
    return CHAR_DIGIT0 + char_code_t'(nib);
  endfunction

  always_comb begin
    row0 = {{8{CHAR_SPACE}}, digit_char(shown.op_tens), digit_char(shown.op_ones)};
    row1 = {CHAR_A, CHAR_COLON, digit_char(shown.a_tens), digit_char(shown.a_ones), CHAR_SPACE,
            CHAR_B, CHAR_COLON, digit_char(shown.b_tens), digit_char(shown.b_ones), CHAR_SPACE};
    row2 = {{8{CHAR_SPACE}}, digit_char(elapsed_bcd.tens), digit_char(elapsed_bcd.ones)};
    text_line = raster_in.sy[9:7];
    text_col  = raster_in.sx[9:6];
    code_next = CHAR_SPACE;  // unused band and horizontal blanking
    if (text_col < 4'd10) begin
      case (text_line)
        3'd0:    code_next = row0[text_col];
        3'd1:    code_next = row1[text_col];
        3'd2:    code_next = row2[text_col];
        default: code_next = CHAR_SPACE;
      endcase
    end
  end

  always_ff @(posedge clk_50M) begin
    if (reset_btn) begin
      raster_out <= RASTER_IDLE;
    end else if (pix_en) begin
      raster_out <= raster_in;
    end
  end

  always_ff @(posedge clk_50M) begin
    if (pix_en) begin
      char_code <= code_next;
      glyph_row <= raster_in.sy[6:3];  // glyph scaled by 8
      glyph_col <= raster_in.sx[5:3];
    end
  end

endmodule

/* text/glyph_fetch.sv */
module glyph_fetch
  import video_pkg::*;
  import text_pkg::*;
(
  input  logic       clk_50M,
  input  logic       reset_btn,
  input  logic       pix_en,
  input  raster_t    raster_in,
  input  char_code_t char_code,
  input  logic [3:0] glyph_row,
  input  logic [2:0] glyph_col,
  output raster_t    raster_out,
  output logic       lit
);

  glyph_t     font [GLYPH_COUNT];
  char_code_t offset;
  logic       in_set;
  glyph_t     glyph;

  initial $readmemh("text/glyph_rom.mem", font);  // one 128-bit word per code from 30h

  always_comb begin
    offset = char_code - GLYPH_FIRST;
    in_set = (char_code >= GLYPH_FIRST) && (offset < char_code_t'(GLYPH_COUNT));
    glyph  = in_set ? font[offset[3:0]] : '0;  // anything else renders blank
  end

  always_ff @(posedge clk_50M) begin
    if (reset_btn) begin
      raster_out <= RASTER_IDLE;
    end else if (pix_en) begin
      raster_out <= raster_in;
    end
  end

  // column 0 is the leftmost, msb of the row byte
  always_ff @(posedge clk_50M) begin
    if (pix_en) lit <= glyph[glyph_row][3'd7 - glyph_col];
  end

endmodule

/* text/glyph_rom.mem */
// one 128-bit glyph per line for codes 30h to 3Ch (digits, colon, A, B); first byte is the top row
00007cc6c6cedef6e6c6c67c00000000
00001838781818181818187e00000000
00007cc6060c183060c0c6fe00000000
00007cc606063c060606c67c00000000
00000c1c3c6cccfe0c0c0c1e00000000
0000fec0c0c0fc060606c67c00000000
00003860c0c0fcc6c6c6c67c00000000
0000fec606060c183030303000000000
00007cc6c6c67cc6c6c6c67c00000000
00007cc6c6c67e0606060c7800000000
00000000181800000018180000000000
000010386cc6c6fec6c6c6c600000000
0000fc6666667c66666666fc00000000

/* text/operand_latch.sv */
module operand_latch
  import text_pkg::*;
(
  input  logic         clk_50M,
  input  logic         reset_btn,
  input  operand_set_t operands,
  input  logic         load_req,
  output logic         load_ack,
  output operand_set_t shown
);

  // four-phase receiver, ack tracks req one clock behind
  always_ff @(posedge clk_50M) begin
    if (reset_btn) begin
      load_ack <= 1'b0;
      shown    <= '0;
    end else begin
      if (load_req && !load_ack) begin
        shown    <= operands;  // host holds operands until ack
        load_ack <= 1'b1;
      end else if (!load_req && load_ack) begin
        load_ack <= 1'b0;
      end
    end
  end

  // ack only rises in answer to a pending request
  ack_needs_req: assert property (@(posedge clk_50M) disable iff (reset_btn)
    $rose(load_ack) |-> $past(load_req))
    else $error("load_ack rose without load_req");

endmodule
